/* rtl/dbg_ring_pkg.sv */
/*
 * Debug ring package
 * Flit, packet field and command types shared by the injector, the ring
 * stations, the collector and the testbench
 */

package dbg_ring_pkg;

   // One ring word
   typedef logic [15:0] dbg_word_t;

   // Flit on every ring link, last marks the final flit of a packet
   typedef struct packed {
      dbg_word_t payload;
      logic      last;
   } dbg_flit_t;

   // Ring address of a station or of the host
   typedef logic [15:0] dbg_id_t;

   // Station register index
   typedef logic [1:0] dbg_reg_addr_t;

   // Command field of the third flit
   typedef enum logic [1:0] {
      CMD_READ  = 2'b00,
      CMD_WRITE = 2'b01,
      CMD_RESP  = 2'b10,
      CMD_ERR   = 2'b11
   } dbg_cmd_e;

   // Command flit layout: command on top, register index at the bottom
   localparam int CMD_MSB = 15;
   localparam int CMD_LSB = 14;

   // Packet on the ring
   //   destination, source, command, data
   // The data flit is sent only with writes and with every response.
   // Host requests enter without a source flit; the injector adds it.

   // Host address on the ring
   localparam dbg_id_t HOST_ID = 16'h0000;

   // Read-only contents of register 0 in each station
   localparam dbg_word_t STATION_TYPE = 16'h5d01;

endpackage

/* rtl/dbg_host_inject.sv */
/*
 * Host injector
 * Takes host request packets and puts them on the debug ring, adding the
 * host source flit right behind the destination flit
 */

`timescale 1ns/10ps

module dbg_host_inject (
   input  logic                    clk_i,
   input  logic                    arst_n_i,

   input  dbg_ring_pkg::dbg_flit_t req_flit_i,
   input  logic                    req_valid_i,
   output logic                    req_ready_o,

   output dbg_ring_pkg::dbg_flit_t ring_flit_o,
   output logic                    ring_valid_o,
   input  logic                    ring_ready_i
);

   import dbg_ring_pkg::*;

   typedef enum logic {
      INJ_DEST,
      INJ_BODY
   } dbg_inject_state_e;

   dbg_inject_state_e state_q;
   // Source flit still owed after the destination flit
   logic              src_pend_q;
   dbg_flit_t         out_flit_q;
   logic              out_valid_q;

   logic              load_ok;
   logic              req_xfer;

   always_comb begin
      load_ok     = !out_valid_q || ring_ready_i;
      // Host waits while the source flit goes out
      req_ready_o = load_ok && !src_pend_q;
      req_xfer    = req_valid_i && req_ready_o;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= INJ_DEST;
         src_pend_q  <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         if (out_valid_q && ring_ready_i) begin
            out_valid_q <= 1'b0;
         end
         if (src_pend_q && load_ok) begin
            out_valid_q <= 1'b1;
            src_pend_q  <= 1'b0;
         end else if (req_xfer) begin
            out_valid_q <= 1'b1;
            case (state_q)
               INJ_DEST: begin
                  state_q    <= INJ_BODY;
                  src_pend_q <= 1'b1;
               end
               default: begin
                  if (req_flit_i.last) begin
                     state_q <= INJ_DEST;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (src_pend_q && load_ok) begin
         out_flit_q <= dbg_flit_t'{payload: HOST_ID, last: 1'b0};
      end else if (req_xfer) begin
         out_flit_q <= req_flit_i;
      end
   end

   assign ring_flit_o  = out_flit_q;
   assign ring_valid_o = out_valid_q;

   // Ring output holds under back-pressure
   a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ring_valid_o && !ring_ready_i |=> ring_valid_o && $stable(ring_flit_o));

endmodule

/* rtl/dbg_ring_station.sv */
/*
 * Debug ring station
 * Forwards packets for other addresses and answers register read and
 * write requests addressed to STATION_ID with a four-flit response
 */

`timescale 1ns/10ps

module dbg_ring_station #(
   parameter dbg_ring_pkg::dbg_id_t STATION_ID = 16'd1
) (
   input  logic                    clk_i,
   input  logic                    arst_n_i,

   input  dbg_ring_pkg::dbg_flit_t up_flit_i,
   input  logic                    up_valid_i,
   output logic                    up_ready_o,

   output dbg_ring_pkg::dbg_flit_t dn_flit_o,
   output logic                    dn_valid_o,
   input  logic                    dn_ready_i
);

   import dbg_ring_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FWD,
      ST_RECV,
      ST_RESP
   } dbg_station_state_e;

   dbg_station_state_e state_q;
   // Flit index inside a consumed request, 0 is the source flit
   logic [1:0]         recv_cnt_q;
   logic [1:0]         resp_cnt_q;
   dbg_word_t          scratch_q [1:3];
   dbg_flit_t          dn_flit_q;
   logic               dn_valid_q;

   // Saved request fields and prepared response
   dbg_id_t            src_q;
   dbg_cmd_e           cmd_q;
   dbg_reg_addr_t      reg_q;
   dbg_cmd_e           resp_cmd_q;
   dbg_word_t          resp_data_q;

   logic               load_ok;
   logic               up_xfer;
   logic               own_dest;
   logic               fwd_load;
   logic               req_end;
   logic               wr_en;
   dbg_cmd_e           cmd_cur;
   dbg_reg_addr_t      reg_cur;
   dbg_cmd_e           resp_cmd_d;
   dbg_word_t          resp_data_d;
   dbg_flit_t          resp_flit;

   always_comb begin
      load_ok = !dn_valid_q || dn_ready_i;
      case (state_q)
         ST_IDLE, ST_FWD: up_ready_o = load_ok;
         ST_RECV:         up_ready_o = 1'b1;
         default:         up_ready_o = 1'b0;
      endcase
      up_xfer  = up_valid_i && up_ready_o;
      own_dest = (up_flit_i.payload == STATION_ID);
      fwd_load = up_xfer && ((state_q == ST_FWD) || (state_q == ST_IDLE && !own_dest));
      req_end  = up_xfer && (state_q == ST_RECV) && up_flit_i.last;
   end

   // Request decode, valid on the last flit of a consumed request
   always_comb begin
      if (recv_cnt_q == 2'd1) begin
         cmd_cur = dbg_cmd_e'(up_flit_i.payload[CMD_MSB:CMD_LSB]);
         reg_cur = up_flit_i.payload[1:0];
      end else begin
         cmd_cur = cmd_q;
         reg_cur = reg_q;
      end
      wr_en       = 1'b0;
      resp_cmd_d  = CMD_ERR;
      resp_data_d = '0;
      if (recv_cnt_q != 2'd0) begin
         if (cmd_cur == CMD_READ) begin
            resp_cmd_d = CMD_RESP;
            case (reg_cur)
               2'd1:    resp_data_d = scratch_q[1];
               2'd2:    resp_data_d = scratch_q[2];
               2'd3:    resp_data_d = scratch_q[3];
               default: resp_data_d = STATION_TYPE;
            endcase
         end else if (cmd_cur == CMD_WRITE && recv_cnt_q == 2'd2 && reg_cur != 2'd0) begin
            // Echo of the written data
            wr_en       = 1'b1;
            resp_cmd_d  = CMD_RESP;
            resp_data_d = up_flit_i.payload;
         end
      end
   end

   always_comb begin
      case (resp_cnt_q)
         2'd0:    resp_flit = dbg_flit_t'{payload: src_q, last: 1'b0};
         2'd1:    resp_flit = dbg_flit_t'{payload: STATION_ID, last: 1'b0};
         2'd2:    resp_flit = dbg_flit_t'{payload: {resp_cmd_q, 12'h000, reg_q}, last: 1'b0};
         default: resp_flit = dbg_flit_t'{payload: resp_data_q, last: 1'b1};
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= ST_IDLE;
         recv_cnt_q   <= 2'd0;
         resp_cnt_q   <= 2'd0;
         dn_valid_q   <= 1'b0;
         scratch_q[1] <= '0;
         scratch_q[2] <= '0;
         scratch_q[3] <= '0;
      end else begin
         if (dn_valid_q && dn_ready_i) begin
            dn_valid_q <= 1'b0;
         end
         if (fwd_load) begin
            dn_valid_q <= 1'b1;
         end
         if (req_end && wr_en) begin
            scratch_q[reg_cur] <= up_flit_i.payload;
         end
         case (state_q)
            ST_IDLE: begin
               // A lone destination flit for us carries nothing to answer
               if (up_xfer && !up_flit_i.last) begin
                  recv_cnt_q <= 2'd0;
                  state_q    <= own_dest ? ST_RECV : ST_FWD;
               end
            end
            ST_FWD: begin
               if (up_xfer && up_flit_i.last) begin
                  state_q <= ST_IDLE;
               end
            end
            ST_RECV: begin
               if (up_xfer) begin
                  if (recv_cnt_q != 2'd3) begin
                     recv_cnt_q <= recv_cnt_q + 2'd1;
                  end
                  if (up_flit_i.last) begin
                     resp_cnt_q <= 2'd0;
                     state_q    <= ST_RESP;
                  end
               end
            end
            default: begin
               if (load_ok) begin
                  dn_valid_q <= 1'b1;
                  resp_cnt_q <= resp_cnt_q + 2'd1;
                  if (resp_cnt_q == 2'd3) begin
                     state_q <= ST_IDLE;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ST_RESP && load_ok) begin
         dn_flit_q <= resp_flit;
      end else if (fwd_load) begin
         dn_flit_q <= up_flit_i;
      end
      if (up_xfer && state_q == ST_RECV) begin
         if (recv_cnt_q == 2'd0) begin
            src_q <= up_flit_i.payload;
         end
         if (recv_cnt_q == 2'd1) begin
            cmd_q <= cmd_cur;
            reg_q <= reg_cur;
         end
      end
      if (req_end) begin
         resp_cmd_q  <= resp_cmd_d;
         resp_data_q <= resp_data_d;
      end
   end

   assign dn_flit_o  = dn_flit_q;
   assign dn_valid_o = dn_valid_q;

   a_dn_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dn_valid_o && !dn_ready_i |=> dn_valid_o && $stable(dn_flit_o));

   // Upstream stays blocked until the response tail has left
   a_resp_blocks_up: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(state_q == ST_RESP) |->
         !up_ready_o until (dn_valid_o && dn_ready_i && dn_flit_o.last));

endmodule

/* rtl/dbg_ring_collect.sv */
/*
 * Ring collector
 * Drains the end of the debug ring, passes host-addressed packets to the
 * host and drops and counts all other packets
 */

`timescale 1ns/10ps

module dbg_ring_collect (
   input  logic                    clk_i,
   input  logic                    arst_n_i,

   input  dbg_ring_pkg::dbg_flit_t ring_flit_i,
   input  logic                    ring_valid_i,
   output logic                    ring_ready_o,

   output dbg_ring_pkg::dbg_flit_t resp_flit_o,
   output logic                    resp_valid_o,
   input  logic                    resp_ready_i,

   output dbg_ring_pkg::dbg_word_t drop_count_o
);

   import dbg_ring_pkg::*;

   // Inside a packet, and the decision made on its first flit
   logic      in_pkt_q;
   logic      drop_q;
   dbg_flit_t resp_flit_q;
   logic      resp_valid_q;
   dbg_word_t drop_cnt_q;

   logic      load_ok;
   logic      is_drop;
   logic      ring_xfer;

   always_comb begin
      load_ok      = !resp_valid_q || resp_ready_i;
      is_drop      = in_pkt_q ? drop_q : (ring_flit_i.payload != HOST_ID);
      // Dropped flits never wait for the host
      ring_ready_o = is_drop || load_ok;
      ring_xfer    = ring_valid_i && ring_ready_o;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_pkt_q     <= 1'b0;
         drop_q       <= 1'b0;
         resp_valid_q <= 1'b0;
         drop_cnt_q   <= '0;
      end else begin
         if (resp_valid_q && resp_ready_i) begin
            resp_valid_q <= 1'b0;
         end
         if (ring_xfer) begin
            if (!is_drop) begin
               resp_valid_q <= 1'b1;
            end
            in_pkt_q <= !ring_flit_i.last;
            if (!in_pkt_q) begin
               drop_q <= is_drop;
               // Saturating count of dropped packets
               if (is_drop && drop_cnt_q != '1) begin
                  drop_cnt_q <= drop_cnt_q + 16'd1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ring_xfer && !is_drop) begin
         resp_flit_q <= ring_flit_i;
      end
   end

   assign resp_flit_o  = resp_flit_q;
   assign resp_valid_o = resp_valid_q;
   assign drop_count_o = drop_cnt_q;

   // Host side stays idle from the head of a foreign packet to its tail
   a_no_resp_in_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ring_valid_i && ring_ready_o && !in_pkt_q && !resp_valid_o &&
         ring_flit_i.payload != HOST_ID && !ring_flit_i.last
      |=> !resp_valid_o until (ring_valid_i && ring_ready_o && ring_flit_i.last));

endmodule

/* rtl/dbg_ring_top.sv */
/*
 * Debug ring top level
 * Host injector, a chain of NUM_STATIONS register stations and the
 * collector on one linear ring
 */

`timescale 1ns/10ps

module dbg_ring_top #(
   parameter int unsigned           NUM_STATIONS = 3,
   parameter dbg_ring_pkg::dbg_id_t BASE_ID      = 16'd1
) (
   input  logic                    clk_i,
   input  logic                    arst_n_i,

   input  dbg_ring_pkg::dbg_flit_t host_req_flit_i,
   input  logic                    host_req_valid_i,
   output logic                    host_req_ready_o,

   output dbg_ring_pkg::dbg_flit_t host_resp_flit_o,
   output logic                    host_resp_valid_o,
   input  logic                    host_resp_ready_i,

   output dbg_ring_pkg::dbg_word_t drop_count_o
);

   import dbg_ring_pkg::*;

   // Link i feeds station i, the last link feeds the collector
   dbg_flit_t [NUM_STATIONS:0] ring_flit;
   logic      [NUM_STATIONS:0] ring_valid;
   logic      [NUM_STATIONS:0] ring_ready;

   dbg_host_inject u_inject (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_flit_i   (host_req_flit_i),
      .req_valid_i  (host_req_valid_i),
      .req_ready_o  (host_req_ready_o),
      .ring_flit_o  (ring_flit[0]),
      .ring_valid_o (ring_valid[0]),
      .ring_ready_i (ring_ready[0])
   );

   for (genvar i = 0; i < NUM_STATIONS; i++) begin : g_station
      dbg_ring_station #(
         .STATION_ID (dbg_id_t'(BASE_ID + i))
      ) u_station (
         .clk_i      (clk_i),
         .arst_n_i   (arst_n_i),
         .up_flit_i  (ring_flit[i]),
         .up_valid_i (ring_valid[i]),
         .up_ready_o (ring_ready[i]),
         .dn_flit_o  (ring_flit[i+1]),
         .dn_valid_o (ring_valid[i+1]),
         .dn_ready_i (ring_ready[i+1])
      );
   end

   dbg_ring_collect u_collect (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .ring_flit_i  (ring_flit[NUM_STATIONS]),
      .ring_valid_i (ring_valid[NUM_STATIONS]),
      .ring_ready_o (ring_ready[NUM_STATIONS]),
      .resp_flit_o  (host_resp_flit_o),
      .resp_valid_o (host_resp_valid_o),
      .resp_ready_i (host_resp_ready_i),
      .drop_count_o (drop_count_o)
   );

endmodule

/* verification/tb_dbg_ring_ref.svh */
/*
 * Debug ring reference model
 * Expected response packets for register requests, and the compare tasks
 */

`ifndef TB_DBG_RING_REF_SVH
`define TB_DBG_RING_REF_SVH

   // Four-flit response, index 0 leaves first
   typedef dbg_flit_t [3:0] resp_pkt_t;

   function automatic dbg_flit_t make_flit(input dbg_word_t payload, input logic last);
      dbg_flit_t f;
      f.payload = payload;
      f.last    = last;
      return f;
   endfunction

   // cur is the model value of the addressed scratch register
   function automatic resp_pkt_t expected_resp(input dbg_id_t dest, input dbg_cmd_e cmd,
                                               input dbg_reg_addr_t addr,
                                               input dbg_word_t wdata, input dbg_word_t cur);
      resp_pkt_t pkt;
      dbg_cmd_e  rcmd;
      dbg_word_t rdata;
      rcmd = CMD_RESP;
      if (cmd == CMD_WRITE) begin
         // Register 0 is read-only
         rcmd  = (addr == 2'd0) ? CMD_ERR : CMD_RESP;
         rdata = (addr == 2'd0) ? 16'h0000 : wdata;
      end else begin
         rdata = (addr == 2'd0) ? STATION_TYPE : cur;
      end
      pkt[0] = make_flit(HOST_ID, 1'b0);
      pkt[1] = make_flit(dest, 1'b0);
      pkt[2] = make_flit({rcmd, 12'h000, addr}, 1'b0);
      pkt[3] = make_flit(rdata, 1'b1);
      return pkt;
   endfunction

   task automatic check_flit(input string name, input dbg_flit_t exp, input dbg_flit_t got);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got));
      end
   endtask

   task automatic check_count(input string name, input dbg_word_t exp, input dbg_word_t got);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %0t ns %s expected %0d got %0d", $time, name, exp, got));
      end
   endtask

`endif

/* verification/tb_dbg_ring.sv */
/*
 * Debug ring testbench
 * Sends register requests through the host port, matches every response
 * against the reference model and checks the drop counter
 */

`timescale 1ns/10ps

module tb_dbg_ring;

   import dbg_ring_pkg::*;

   localparam int      NUM_STATIONS = 3;
   localparam dbg_id_t BASE_ID      = 16'd1;
   localparam int      NUM_RAND     = 60;
   // Directed requests 3 + 20 + 6 + 4, then the random mix
   localparam int      NUM_REQ      = 33 + NUM_RAND;

   `include "tb_dbg_ring_ref.svh"

   logic      clk_i = 1'b0;
   logic      arst_n_i;
   dbg_flit_t host_req_flit_i;
   logic      host_req_valid_i;
   logic      host_req_ready_o;
   dbg_flit_t host_resp_flit_o;
   logic      host_resp_valid_o;
   logic      host_resp_ready_i = 1'b0;
   dbg_word_t drop_count_o;

   int        seed = 53273;
   dbg_word_t model_regs [NUM_STATIONS][4];
   resp_pkt_t exp_q [$];
   resp_pkt_t rx_pkt;
   int        rx_cnt = 0;

   dbg_ring_top #(
      .NUM_STATIONS (NUM_STATIONS),
      .BASE_ID      (BASE_ID)
   ) UUT (
      .clk_i             (clk_i),
      .arst_n_i          (arst_n_i),
      .host_req_flit_i   (host_req_flit_i),
      .host_req_valid_i  (host_req_valid_i),
      .host_req_ready_o  (host_req_ready_o),
      .host_resp_flit_o  (host_resp_flit_o),
      .host_resp_valid_o (host_resp_valid_o),
      .host_resp_ready_i (host_resp_ready_i),
      .drop_count_o      (drop_count_o)
   );

   always #20 clk_i = ~clk_i;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   // One flit on the host port, held until accepted
   task automatic send_flit(input dbg_word_t payload, input logic last);
      @(negedge clk_i);
      host_req_flit_i.payload = payload;
      host_req_flit_i.last    = last;
      host_req_valid_i        = 1'b1;
      @(posedge clk_i);
      while (!host_req_ready_o) begin
         @(posedge clk_i);
      end
   endtask

   task automatic send_req(input dbg_id_t dest, input dbg_cmd_e cmd,
                           input dbg_reg_addr_t addr, input dbg_word_t data);
      int st;
      st = int'(dest) - int'(BASE_ID);
      // Ids outside the chain expect no response
      if (st >= 0 && st < NUM_STATIONS) begin
         exp_q.push_back(expected_resp(dest, cmd, addr, data, model_regs[st][addr]));
         if (cmd == CMD_WRITE && addr != 2'd0) begin
            model_regs[st][addr] = data;
         end
      end
      send_flit(dest, 1'b0);
      send_flit({cmd, 12'h000, addr}, cmd != CMD_WRITE);
      if (cmd == CMD_WRITE) begin
         send_flit(data, 1'b1);
      end
   endtask

   task automatic wait_drain();
      @(negedge clk_i);
      host_req_valid_i = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
   endtask

   // Oldest pending response of the same station
   task automatic match_resp();
      int idx;
      idx = -1;
      if (rx_cnt != 4) begin
         abort_run($sformatf("Response at %0t ns has %0d flits instead of four", $time, rx_cnt));
      end
      foreach (exp_q[i]) begin
         if (idx < 0 && exp_q[i][1].payload == rx_pkt[1].payload) begin
            idx = i;
         end
      end
      if (idx < 0) begin
         abort_run($sformatf("Response from source %h at %0t ns has no pending request",
                             rx_pkt[1].payload, $time));
      end
      for (int k = 0; k < 4; k++) begin
         check_flit($sformatf("host_resp_flit_o[%0d]", k), exp_q[idx][k], rx_pkt[k]);
      end
      exp_q.delete(idx);
   endtask

   always @(negedge clk_i) begin
      host_resp_ready_i = (($random(seed) & 3) != 0) && arst_n_i;
   end

   always @(posedge clk_i) begin
      if (arst_n_i && host_resp_valid_o && host_resp_ready_i) begin
         if (rx_cnt == 4) begin
            abort_run("Response packet on host_resp is longer than four flits");
         end
         rx_pkt[rx_cnt] = host_resp_flit_o;
         rx_cnt         = rx_cnt + 1;
         if (host_resp_flit_o.last) begin
            match_resp();
            rx_cnt = 0;
         end
      end
   end

   initial begin : watchdog
      repeat (NUM_REQ * 200) @(posedge clk_i);
      abort_run("Timeout, responses still missing at the end of the test time");
   end

   initial begin : stimulus
      dbg_word_t   drop_base;
      logic [31:0] rnd;
      logic [31:0] rnd_data;
      arst_n_i         = 1'b0;
      host_req_flit_i  = '0;
      host_req_valid_i = 1'b0;
      foreach (model_regs[s, r]) begin
         model_regs[s][r] = '0;
      end
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      check_count("drop_count_o", 16'd0, drop_count_o);

      // Type register of each station
      for (int s = 0; s < NUM_STATIONS; s++) begin
         send_req(dbg_id_t'(BASE_ID + s), CMD_READ, 2'd0, 16'h0000);
      end
      wait_drain();

      // Distinct scratch values per station and register
      for (int s = 0; s < NUM_STATIONS; s++) begin
         for (int r = 1; r < 4; r++) begin
            send_req(dbg_id_t'(BASE_ID + s), CMD_WRITE, dbg_reg_addr_t'(r),
                     dbg_word_t'(16'ha000 | (s << 4) | r));
         end
      end
      send_req(BASE_ID, CMD_WRITE, 2'd2, 16'h1234);
      for (int s = 0; s < NUM_STATIONS; s++) begin
         for (int r = 1; r < 4; r++) begin
            send_req(dbg_id_t'(BASE_ID + s), CMD_READ, dbg_reg_addr_t'(r), 16'h0000);
         end
      end
      send_req(BASE_ID, CMD_READ, 2'd2, 16'h0000);
      wait_drain();

      // Writes to register 0 are refused
      for (int s = 0; s < NUM_STATIONS; s++) begin
         send_req(dbg_id_t'(BASE_ID + s), CMD_WRITE, 2'd0, 16'hbeef);
         send_req(dbg_id_t'(BASE_ID + s), CMD_READ, 2'd0, 16'h0000);
      end
      wait_drain();

      // Unclaimed ids, the trailing read of the last station marks the drain
      drop_base = drop_count_o;
      send_req(dbg_id_t'(BASE_ID + NUM_STATIONS), CMD_READ, 2'd1, 16'h0000);
      send_req(16'h0100, CMD_WRITE, 2'd3, 16'h7777);
      send_req(16'hffff, CMD_READ, 2'd0, 16'h0000);
      send_req(dbg_id_t'(BASE_ID + NUM_STATIONS - 1), CMD_READ, 2'd1, 16'h0000);
      wait_drain();
      check_count("drop_count_o", drop_base + 16'd3, drop_count_o);

      // Back-to-back random traffic
      for (int n = 0; n < NUM_RAND; n++) begin
         rnd      = $random(seed);
         rnd_data = $random(seed);
         send_req(dbg_id_t'(BASE_ID + (rnd[15:0] % NUM_STATIONS)),
                  rnd[16] ? CMD_WRITE : CMD_READ, rnd[18:17], rnd_data[15:0]);
      end
      wait_drain();
      check_count("drop_count_o", drop_base + 16'd3, drop_count_o);

      if (rx_cnt != 0) begin
         abort_run("Partial response left on host_resp after the last request");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

/* vlog.f */
+incdir+verification
rtl/dbg_ring_pkg.sv
rtl/dbg_host_inject.sv
rtl/dbg_ring_station.sv
rtl/dbg_ring_collect.sv
rtl/dbg_ring_top.sv
verification/tb_dbg_ring.sv

/* Bender.yml */
package:
  name: dbg_ring

sources:
  # RTL in compile order
  - files:
      - rtl/dbg_ring_pkg.sv
      - rtl/dbg_host_inject.sv
      - rtl/dbg_ring_station.sv
      - rtl/dbg_ring_collect.sv
      - rtl/dbg_ring_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_dbg_ring.sv
